// File: memBusTop.f
rtl/busPkg.sv
rtl/mapPkg.sv
rtl/wbManager.sv
rtl/wbDecoder.sv
rtl/sramSlave.sv
rtl/regSlave.sv
rtl/memBusTop.sv
sim/memBus_assert.sv
sim/memBusTb.sv

// File: rtl/busPkg.sv
package busPkg;

    // payload widths on the bus
    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;

    // one enable per byte lane of dataT
    typedef logic [3:0] selT;

    // cpu side request code
    typedef logic [1:0] rwiT;

    // read 10, write 01, idle 00
    localparam rwiT rwiRead  = 2'b10;
    localparam rwiT rwiWrite = 2'b01;
    localparam rwiT rwiIdle  = 2'b00;

    // 11 is reserved and treated like idle by the manager

endpackage

// File: rtl/mapPkg.sv
package mapPkg;

    import busPkg::*;

    // word sram region, size aligned
    localparam addrT sramBase  = 32'h0000_0000;
    localparam int   sramWords = 256;
    localparam int   sramIdxW  = $clog2(sramWords);
    localparam addrT sramMask  = ~(addrT'(sramWords * 4) - 1);

    // control register region, size aligned
    localparam addrT regBase  = 32'h0000_1000;
    localparam int   regSpan  = 256;
    localparam int   regOffW  = $clog2(regSpan);
    localparam addrT regMask  = ~(addrT'(regSpan) - 1);

    // scratch words sit at offsets 0x0 to 0xC
    localparam int scratchCount = 4;
    localparam int scratchIdxW  = $clog2(scratchCount);

    // read only count of scratch writes
    localparam addrT writeCountOffset = 32'h0000_0010;

endpackage

// File: rtl/memBusTop.sv
`timescale 1ns/1ps

module memBusTop import busPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  rwiT  rwi,
    input  addrT addr,
    input  dataT wrData,
    input  selT  byteEn,
    output dataT rdData,
    output logic busy,
    output logic accessErr
);

    // manager to decoder and slaves
    addrT adr;
    dataT datW;
    selT  sel;
    logic we;
    logic stb;
    logic cyc;

    // merged response back to the manager
    logic ack;
    logic err;
    dataT datR;

    // per slave strobes and responses
    logic sramStb;
    logic sramAck;
    dataT sramDatR;
    logic regStb;
    logic regAck;
    dataT regDatR;

    wbManager manager (
        .clk(clk),
        .rstN(rstN),
        .rwi(rwi),
        .addr(addr),
        .wrData(wrData),
        .byteEn(byteEn),
        .ack(ack),
        .err(err),
        .datR(datR),
        .adr(adr),
        .datW(datW),
        .sel(sel),
        .we(we),
        .stb(stb),
        .cyc(cyc),
        .rdData(rdData),
        .busy(busy),
        .accessErr(accessErr)
    );

    wbDecoder decoder (
        .clk(clk),
        .rstN(rstN),
        .adr(adr),
        .stb(stb),
        .cyc(cyc),
        .sramAck(sramAck),
        .sramDatR(sramDatR),
        .regAck(regAck),
        .regDatR(regDatR),
        .sramStb(sramStb),
        .regStb(regStb),
        .ack(ack),
        .err(err),
        .datR(datR)
    );

    sramSlave sram (
        .clk(clk),
        .rstN(rstN),
        .stb(sramStb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .sel(sel),
        .ack(sramAck),
        .datR(sramDatR)
    );

    regSlave regs (
        .clk(clk),
        .rstN(rstN),
        .stb(regStb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .sel(sel),
        .ack(regAck),
        .datR(regDatR)
    );

endmodule

// File: rtl/regSlave.sv
`timescale 1ns/1ps

module regSlave import busPkg::*, mapPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stb,
    input  logic we,
    input  addrT adr,
    input  dataT datW,
    input  selT  sel,
    output logic ack,
    output dataT datR
);

    typedef logic [regOffW-3:0] wordOffT;

    dataT scratch [scratchCount];
    dataT writeCount;

    // wait state between strobe and ack
    logic waitStep;

    wordOffT wordOff;
    logic [scratchIdxW-1:0] idx;
    logic isScratch;
    logic isCount;

    assign wordOff   = adr[regOffW-1:2];
    assign idx       = wordOff[scratchIdxW-1:0];
    assign isScratch = wordOff < wordOffT'(scratchCount);
    assign isCount   = wordOff == writeCountOffset[regOffW-1:2];

    // strobe, wait, then a single ack pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            waitStep <= 1'b0;
            ack      <= 1'b0;
        end else begin
            waitStep <= stb && !ack && !waitStep;
            ack      <= waitStep;
        end
    end

    // the access itself happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < scratchCount; i++) begin
                scratch[i] <= '0;
            end
            writeCount <= '0;
        end else if (waitStep && we && isScratch) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    scratch[idx][8*i +: 8] <= datW[8*i +: 8];
                end
            end
            writeCount <= writeCount + dataT'(1);
        end
    end

    // unused offsets read as zero
    always_ff @(posedge clk) begin
        if (waitStep) begin
            if (isScratch) begin
                datR <= scratch[idx];
            end else if (isCount) begin
                datR <= writeCount;
            end else begin
                datR <= '0;
            end
        end
    end

endmodule

// File: rtl/sramSlave.sv
`timescale 1ns/1ps

module sramSlave import busPkg::*, mapPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stb,
    input  logic we,
    input  addrT adr,
    input  dataT datW,
    input  selT  sel,
    output logic ack,
    output dataT datR
);

    dataT mem [sramWords];

    logic [sramIdxW-1:0] idx;
    logic access;

    // word index, byte offset bits dropped
    assign idx = adr[sramIdxW+1:2];

    // stb stays up during the ack cycle, so act only once
    assign access = stb && !ack;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel[i]) begin
                        mem[idx][8*i +: 8] <= datW[8*i +: 8];
                    end
                end
            end
            // old word on a write, not looked at by the manager
            datR <= mem[idx];
        end
    end

endmodule

// File: rtl/wbDecoder.sv
`timescale 1ns/1ps

module wbDecoder import busPkg::*, mapPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  addrT adr,
    input  logic stb,
    input  logic cyc,
    input  logic sramAck,
    input  dataT sramDatR,
    input  logic regAck,
    input  dataT regDatR,
    output logic sramStb,
    output logic regStb,
    output logic ack,
    output logic err,
    output dataT datR
);

    logic hitSram;
    logic hitReg;
    logic unmapped;
    logic active;

    // set one cycle after an unmapped strobe
    logic errAck;

    // both regions are aligned to their size, so a mask is enough
    assign hitSram  = (adr & sramMask) == sramBase;
    assign hitReg   = (adr & regMask) == regBase;
    assign unmapped = !hitSram && !hitReg;

    assign active = stb && cyc;

    // at most one slave sees the strobe
    assign sramStb = active && hitSram;
    assign regStb  = active && hitReg;

    // nobody else answers an unmapped address, so the decoder
    // closes the cycle itself
    always_ff @(posedge clk) begin
        if (!rstN) begin
            errAck <= 1'b0;
        end else begin
            errAck <= active && unmapped && !errAck;
        end
    end

    assign ack = sramAck || regAck || errAck;
    assign err = errAck;

    // data of whichever slave answered, zero on an error ack
    always_comb begin
        if (sramAck) begin
            datR = sramDatR;
        end else if (regAck) begin
            datR = regDatR;
        end else begin
            datR = '0;
        end
    end

endmodule

// File: rtl/wbManager.sv
`timescale 1ns/1ps

module wbManager import busPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  rwiT  rwi,
    input  addrT addr,
    input  dataT wrData,
    input  selT  byteEn,
    input  logic ack,
    input  logic err,
    input  dataT datR,
    output addrT adr,
    output dataT datW,
    output selT  sel,
    output logic we,
    output logic stb,
    output logic cyc,
    output dataT rdData,
    output logic busy,
    output logic accessErr
);

    typedef enum logic [1:0] {
        idle,
        bus,
        done
    } stateT;

    stateT state;

    // response held from ack until busy falls
    dataT capData;
    logic capErr;

    logic request;

    assign request = (rwi == rwiRead) || (rwi == rwiWrite);

    // one cycle in flight, strobe covers the whole bus state
    assign stb  = (state == bus);
    assign cyc  = (state == bus);
    assign busy = (state != idle);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (request) begin
                        state <= bus;
                    end
                end
                bus: begin
                    if (ack) begin
                        state <= done;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // rwi is only looked at while idle
    always_ff @(posedge clk) begin
        if (state == idle && request) begin
            adr  <= addr;
            datW <= wrData;
            sel  <= byteEn;
            we   <= (rwi == rwiWrite);
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus && ack) begin
            capData <= datR;
            capErr  <= err;
        end
    end

    // results move to the cpu side together with busy falling
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdData    <= '0;
            accessErr <= 1'b0;
        end else if (state == done) begin
            accessErr <= capErr;
            // writes keep the last read word visible
            if (!we) begin
                rdData <= capData;
            end
        end
    end

endmodule

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module memBusTb -f memBusTop.f -o memBusSim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/memBusSim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Test passed" sim.log && exit 0 || exit 1

// File: sim/memBusInput.txt
# columns: test rwi addr byteEn wrData expRdData expAccessErr
# test is decimal, the rest hex; rwi 2 is read, 1 is write
1  2 00001000 f 00000000 00000000 0
2  2 00001004 f 00000000 00000000 0
3  2 00001008 f 00000000 00000000 0
4  2 0000100c f 00000000 00000000 0
5  2 00001010 f 00000000 00000000 0
6  1 00000000 f 11223344 00000000 0
7  1 00000004 f a5a50f0f 00000000 0
8  1 000003fc f deadbeef 00000000 0
9  2 00000000 f 00000000 11223344 0
10 2 00000004 f 00000000 a5a50f0f 0
11 2 000003fc f 00000000 deadbeef 0
12 1 00000004 5 11112222 deadbeef 0
13 2 00000004 f 00000000 a5110f22 0
14 1 00001000 f cafef00d a5110f22 0
15 1 00001000 2 00005500 a5110f22 0
16 2 00001000 f 00000000 cafe550d 0
17 2 00001010 f 00000000 00000002 0
18 1 0000100c f 0badc0de 00000002 0
19 1 00001010 f ffffffff 00000002 0
20 1 00001020 f 12345678 00000002 0
21 2 00001020 f 00000000 00000000 0
22 2 00001010 f 00000000 00000003 0
23 2 0000100c f 00000000 0badc0de 0
24 1 00002000 f 5555aaaa 0badc0de 1
25 2 00002000 f 00000000 00000000 1
26 2 00000000 f 00000000 11223344 0
27 2 000003fc f 00000000 deadbeef 0
28 2 00001010 f 00000000 00000003 0
29 2 00000400 f 00000000 00000000 1
30 2 00001008 f 00000000 00000000 0
31 1 000003fc 8 77000000 00000000 0
32 2 000003fc f 00000000 77adbeef 0

// File: sim/memBusTb.sv
`timescale 1ns/1ps

module memBusTb import busPkg::*, mapPkg::*; ();

    logic clk;
    logic rstN;
    rwiT  rwi;
    addrT addr;
    dataT wrData;
    selT  byteEn;
    dataT rdData;
    logic busy;
    logic accessErr;

    // requests and expected results from the input file
    int   numQ[$];
    rwiT  rwiQ[$];
    addrT addrQ[$];
    selT  selQ[$];
    dataT dataQ[$];
    dataT expRdQ[$];
    logic expErrQ[$];

    int cycleCount;
    int cycleLimit;
    int passCount;
    int failCount;
    int otherErrors;

    memBusTop dut (
        .clk(clk),
        .rstN(rstN),
        .rwi(rwi),
        .addr(addr),
        .wrData(wrData),
        .byteEn(byteEn),
        .rdData(rdData),
        .busy(busy),
        .accessErr(accessErr)
    );

    always #4 clk = ~clk;

    // watchdog, the limit is set once the request list is known
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("run stopped at cycle %0d, a request never completed", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // register region has one extra wait state
    function automatic int latencyFor(input addrT a);
        if (a >= regBase && a < regBase + addrT'(regSpan)) begin
            return 4;
        end
        return 3;
    endfunction

    task automatic loadRequests();
        int    fd;
        int    n;
        int    num;
        rwiT   fRwi;
        addrT  fAddr;
        selT   fSel;
        dataT  fData;
        dataT  fRd;
        logic  fErr;
        string line;
        fd = $fopen("sim/memBusInput.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/memBusInput.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h %h", num, fRwi, fAddr, fSel, fData, fRd, fErr);
            if (n == 7) begin
                numQ.push_back(num);
                rwiQ.push_back(fRwi);
                addrQ.push_back(fAddr);
                selQ.push_back(fSel);
                dataQ.push_back(fData);
                expRdQ.push_back(fRd);
                expErrQ.push_back(fErr);
            end else if (n > 0) begin
                $display("malformed line in input file: %s", line);
                otherErrors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic runRequest(input int i);
        int gap;
        int cycles;
        int wantCycles;
        bit bad;
        gap = $urandom % 4;
        bad = 1'b0;
        wantCycles = latencyFor(addrQ[i]);
        repeat (gap) stepCycle();
        rwi    = rwiQ[i];
        addr   = addrQ[i];
        wrData = dataQ[i];
        byteEn = selQ[i];
        stepCycle();
        // past the accepting edge, the request stays one cycle wide
        rwi = rwiIdle;
        if (!busy) begin
            $display("test %0d: busy did not rise after the request", numQ[i]);
            bad = 1'b1;
        end else begin
            cycles = 0;
            while (busy) begin
                stepCycle();
                cycles++;
            end
            if (cycles != wantCycles) begin
                $display("test %0d: busy fell %0d cycles after acceptance instead of %0d",
                    numQ[i], cycles, wantCycles);
                bad = 1'b1;
            end
        end
        if (rdData !== expRdQ[i]) begin
            $display("Error: rdData expected %h, got %h in test %0d", expRdQ[i], rdData, numQ[i]);
            bad = 1'b1;
        end
        if (accessErr !== expErrQ[i]) begin
            $display("Error: accessErr expected %h, got %h in test %0d",
                expErrQ[i], accessErr, numQ[i]);
            bad = 1'b1;
        end
        if (bad) begin
            $display("test %0d has errors", numQ[i]);
            failCount++;
        end else begin
            $display("test %0d ok", numQ[i]);
            passCount++;
        end
    endtask

    initial begin
        void'($urandom(32'h3885_bb30));
        clk         = 1'b0;
        rstN        = 1'b0;
        rwi         = rwiIdle;
        addr        = '0;
        wrData      = '0;
        byteEn      = '0;
        cycleCount  = 0;
        cycleLimit  = 0;
        passCount   = 0;
        failCount   = 0;
        otherErrors = 0;
        loadRequests();
        if (numQ.size() == 0) begin
            $display("no requests found in the input file");
            otherErrors++;
        end
        cycleLimit = numQ.size() * 8 + 50;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        // results and busy start out cleared
        if (busy !== 1'b0) begin
            $display("Error: busy expected %h, got %h after reset", 1'b0, busy);
            otherErrors++;
        end
        if (accessErr !== 1'b0) begin
            $display("Error: accessErr expected %h, got %h after reset", 1'b0, accessErr);
            otherErrors++;
        end
        for (int i = 0; i < numQ.size(); i++) begin
            runRequest(i);
        end
        $display("%0d tests ok, %0d tests with errors, %0d other errors",
            passCount, failCount, otherErrors);
        if (failCount == 0 && otherErrors == 0 && passCount > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim/memBus_assert.sv
`timescale 1ns/1ps

module memBusAssert import busPkg::*; (
    input logic clk,
    input logic rstN,
    input rwiT  rwi,
    input logic busy,
    input logic stb,
    input logic cyc,
    input logic ack
);

    logic request;

    assign request = (rwi == rwiRead) || (rwi == rwiWrite);

    // stb and cyc both close the cycle right after the acknowledge
    cycEnds: assert property (@(posedge clk) disable iff (!rstN) stb && ack |=> !stb && !cyc)
        else $error("stb or cyc still high after ack");

    // once raised, stb waits for the acknowledge
    stbHeld: assert property (@(posedge clk) disable iff (!rstN) stb && !ack |=> stb)
        else $error("stb dropped before ack");

    busyRise: assert property (@(posedge clk) disable iff (!rstN) !busy && request |=> busy)
        else $error("busy did not rise after an accepted request");

    ackNeedsStb: assert property (@(posedge clk) disable iff (!rstN) ack |-> stb)
        else $error("ack without stb");

endmodule

bind wbManager memBusAssert checks (
    .clk(clk),
    .rstN(rstN),
    .rwi(rwi),
    .busy(busy),
    .stb(stb),
    .cyc(cyc),
    .ack(ack)
);
